/* dv/mul_input.txt */
# op rs1 rs2 expected, all hex
# op: 0 MUL, 1 MULH, 2 MULHSU, 3 MULHU
0 00000000 00000000 00000000
0 00000003 00000007 00000015
0 ffffffff ffffffff 00000001
0 80000000 ffffffff 80000000
0 12345678 00000010 23456780
0 fffffffd 00000003 fffffff7
1 ffffffff ffffffff 00000000
1 80000000 80000000 40000000
1 80000000 7fffffff c0000000
1 ffffffff 00000005 ffffffff
1 00000000 80000000 00000000
1 00000003 fffffffd ffffffff
2 ffffffff ffffffff ffffffff
2 80000000 ffffffff 80000000
2 7fffffff ffffffff 7ffffffe
2 00000000 ffffffff 00000000
3 ffffffff ffffffff fffffffe
3 80000000 80000000 40000000
3 00000002 80000000 00000001

/* build.f */
hw/mul_pkg.sv
hw/mul_issue.sv
hw/booth_r4_encoder.sv
hw/csa_level.sv
hw/mul_result_stage.sv
hw/mul_top.sv
dv/mul_assert.sv
dv/mul_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= mul_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Everything OK

BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard hw/*.sv dv/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* dv/mul_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module mul_tb;

  localparam int IN_DEPTH    = 4;
  localparam int OUT_CREDITS = 4;
  localparam int RST_CYCLES  = 3;
  localparam int N_RANDOM    = 200;
  localparam int CYC_PER_REQ = 40;
  localparam int DLY_N       = 64;
  localparam int MODE_NOW    = 0;
  localparam int MODE_DELAY  = 1;
  localparam int MODE_HOLD   = 2;

  logic               clk_i     = 1'b0;
  logic               rst_n_i;
  logic               req_valid_i;
  mul_pkg::mul_req_t  req_i;
  logic               req_crd_o;
  logic               res_valid_o;
  mul_pkg::mul_res_t  res_o;
  logic               res_crd_i = 1'b0;

  integer             seed;
  int                 link_errors;
  int                 credits;
  int                 crd_seen;
  int                 sent;
  int                 crd_mode;
  int                 n_total;
  int unsigned        delay_tbl [DLY_N];
  mul_pkg::mul_tag_t  next_tag;
  mul_pkg::mul_req_t  dir_req_q [$];
  mul_pkg::mul_data_t dir_exp_q [$];
  mul_pkg::mul_res_t  exp_q [$];
  string              name_q [$];

  // Owned by the receiver.
  int                 val_errors = 0;
  int                 rx_errors  = 0;
  int                 res_count  = 0;
  int                 buf_used   = 0;
  int                 crd_wait   = 0;
  int                 dly_idx    = 0;

  mul_top #(
    .IN_DEPTH    (IN_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) i_mul_top (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .req_crd_o   (req_crd_o),
    .res_valid_o (res_valid_o),
    .res_o       (res_o),
    .res_crd_i   (res_crd_i)
  );

  always #10 clk_i = ~clk_i;

  function automatic mul_pkg::mul_data_t ref_mul(input mul_pkg::mul_op_t op,
                                                 input mul_pkg::mul_data_t a,
                                                 input mul_pkg::mul_data_t b);
    logic [63:0] x;
    logic [63:0] y;
    logic [63:0] p;
    x = {32'b0, a};
    y = {32'b0, b};
    if (op == mul_pkg::OP_MULH || op == mul_pkg::OP_MULHSU) begin
      x = {{32{a[31]}}, a};
    end
    if (op == mul_pkg::OP_MULH) begin
      y = {{32{b[31]}}, b};
    end
    // Product modulo 2^64 is the same for signed and unsigned views.
    p = x * y;
    return (op == mul_pkg::OP_MUL) ? p[31:0] : p[63:32];
  endfunction

  task automatic report_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    val_errors++;
    $display("** Error %s: expected %h, actual %h", name, exp, act);
  endtask

  // Every falling edge passes through here, so no returned credit is missed.
  task automatic tick_sender();
    @(negedge clk_i);
    if (req_crd_o) begin
      credits++;
      crd_seen++;
    end
    req_valid_i = 1'b0;
  endtask

  task automatic send_req(input mul_pkg::mul_op_t op, input mul_pkg::mul_data_t a,
                          input mul_pkg::mul_data_t b, input mul_pkg::mul_data_t exp_data,
                          input string name);
    tick_sender();
    while (credits == 0) begin
      tick_sender();
    end
    req_i       = {op, next_tag, a, b};
    req_valid_i = 1'b1;
    credits--;
    sent++;
    exp_q.push_back({next_tag, exp_data});
    name_q.push_back(name);
    next_tag++;
  endtask

  task automatic wait_idle();
    while (exp_q.size() != 0 || buf_used != 0 || credits != IN_DEPTH) begin
      tick_sender();
    end
  endtask

  task automatic set_crd_mode(input int mode);
    @(posedge clk_i);
    crd_mode = mode;
  endtask

  task automatic read_vectors();
    int                fd;
    int                code;
    string             line;
    logic [31:0]       f_op;
    logic [31:0]       f_a;
    logic [31:0]       f_b;
    logic [31:0]       f_exp;
    fd = $fopen("dv/mul_input.txt", "r");
    if (fd == 0) begin
      link_errors++;
      $display("Could not open the vector file dv/mul_input.txt");
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code != 0) begin
          // Comment and blank lines do not scan to four fields.
          if ($sscanf(line, "%h %h %h %h", f_op, f_a, f_b, f_exp) == 4) begin
            dir_req_q.push_back({f_op[1:0], 4'h0, f_a, f_b});
            dir_exp_q.push_back(f_exp);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  always @(negedge clk_i) begin : receiver
    mul_pkg::mul_res_t exp_res;
    string             name;
    res_crd_i = 1'b0;
    if (rst_n_i && res_valid_o) begin
      res_count++;
      buf_used++;
      if (exp_q.size() == 0) begin
        rx_errors++;
        $display("Result with tag %h arrived with no request pending", res_o.tag);
      end else begin
        exp_res = exp_q.pop_front();
        name    = name_q.pop_front();
        if (res_o.data !== exp_res.data) begin
          report_value(name, exp_res.data, res_o.data);
        end
        if (res_o.tag !== exp_res.tag) begin
          report_value({name, "_tag"}, 32'(exp_res.tag), 32'(res_o.tag));
        end
      end
      if (buf_used > OUT_CREDITS) begin
        rx_errors++;
        $display("Receiver holds %0d results but has only %0d buffer entries",
                 buf_used, OUT_CREDITS);
      end
    end
    if (buf_used > 0 && crd_mode != MODE_HOLD) begin
      if (crd_mode == MODE_NOW || crd_wait == 0) begin
        res_crd_i = 1'b1;
        buf_used--;
        crd_wait  = delay_tbl[dly_idx];
        dly_idx   = (dly_idx + 1) % DLY_N;
      end else begin
        crd_wait--;
      end
    end
  end

  initial begin : watchdog
    wait (n_total > 0);
    repeat (n_total * CYC_PER_REQ + RST_CYCLES) @(posedge clk_i);
    $display("Timeout: the requests did not all complete in time");
    $display("Something failed");
    $finish;
  end

  initial begin : main
    mul_pkg::mul_op_t   op;
    mul_pkg::mul_data_t a;
    mul_pkg::mul_data_t b;
    int                 hold_base;
    rst_n_i     = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    seed        = 32'hacf8;
    link_errors = 0;
    credits     = IN_DEPTH;
    crd_seen    = 0;
    sent        = 0;
    crd_mode    = MODE_NOW;
    n_total     = 0;
    next_tag    = '0;
    for (int i = 0; i < DLY_N; i++) begin
      delay_tbl[i] = $unsigned($random(seed)) % 8;
    end
    read_vectors();
    n_total = dir_req_q.size() + N_RANDOM + IN_DEPTH + OUT_CREDITS;

    repeat (RST_CYCLES) tick_sender();
    rst_n_i = 1'b1;

    // Quiet links with nothing sent.
    repeat (5) begin
      tick_sender();
      if (req_crd_o || res_valid_o) begin
        link_errors++;
        $display("Link activity after reset with no request sent");
      end
    end

    foreach (dir_req_q[i]) begin
      send_req(dir_req_q[i].op, dir_req_q[i].rs1, dir_req_q[i].rs2, dir_exp_q[i],
               $sformatf("dir_%0d", i));
    end
    wait_idle();

    set_crd_mode(MODE_DELAY);
    for (int i = 0; i < N_RANDOM; i++) begin
      op = 2'($random(seed));
      a  = $random(seed);
      b  = $random(seed);
      if (($random(seed) & 3) == 0) begin
        tick_sender();
      end
      send_req(op, a, b, ref_mul(op, a, b), $sformatf("rnd_%0d", i));
    end
    wait_idle();

    // Withheld credits: only OUT_CREDITS results may come out.
    set_crd_mode(MODE_HOLD);
    hold_base = res_count;
    for (int i = 0; i < IN_DEPTH + OUT_CREDITS; i++) begin
      op = 2'($random(seed));
      a  = $random(seed);
      b  = $random(seed);
      send_req(op, a, b, ref_mul(op, a, b), $sformatf("hold_%0d", i));
    end
    repeat (20) tick_sender();
    if (res_count - hold_base != OUT_CREDITS) begin
      link_errors++;
      $display("With credits withheld %0d results arrived instead of %0d",
               res_count - hold_base, OUT_CREDITS);
    end
    set_crd_mode(MODE_NOW);
    wait_idle();

    if (crd_seen != sent) begin
      link_errors++;
      $display("Sent %0d requests but got %0d request credits back", sent, crd_seen);
    end
    if (credits != IN_DEPTH) begin
      link_errors++;
      $display("Sender ends with %0d credits instead of %0d", credits, IN_DEPTH);
    end
    if (res_count != sent) begin
      link_errors++;
      $display("Sent %0d requests but received %0d results", sent, res_count);
    end

    $display("Errors: %0d value, %0d receive, %0d link", val_errors, rx_errors, link_errors);
    if (val_errors == 0 && rx_errors == 0 && link_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* dv/mul_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module mul_assert #(
  parameter int IN_DEPTH    = 4,
  parameter int OUT_CREDITS = 4
) (
  input logic clk_i,
  input logic rst_n_i,
  input logic req_valid_i,
  input logic req_crd_o,
  input logic res_valid_o,
  input logic res_crd_i
);

  int in_crd_q;
  int out_crd_q;

  // Credits as the sender and the unit see them.
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      in_crd_q  <= IN_DEPTH;
      out_crd_q <= OUT_CREDITS;
    end else begin
      in_crd_q  <= in_crd_q - int'(req_valid_i) + int'(req_crd_o);
      out_crd_q <= out_crd_q - int'(res_valid_o) + int'(res_crd_i);
    end
  end

  quiet_in_reset: assert property (@(posedge clk_i)
    (!rst_n_i && !$past(rst_n_i)) |-> (!res_valid_o && !req_crd_o))
    else $error("Link active while in reset");

  res_has_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    res_valid_o |-> (out_crd_q > 0))
    else $error("Result sent with no output credit");

  // A credit returned in the same cycle may be spent at once.
  req_has_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i |-> (in_crd_q > 0 || req_crd_o))
    else $error("Request sent with no input credit");

endmodule

bind mul_top mul_assert #(
  .IN_DEPTH    (IN_DEPTH),
  .OUT_CREDITS (OUT_CREDITS)
) i_mul_assert (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .req_valid_i (req_valid_i),
  .req_crd_o   (req_crd_o),
  .res_valid_o (res_valid_o),
  .res_crd_i   (res_crd_i)
);

`default_nettype wire

/* hw/mul_top.sv */
`timescale 1ns/1ns
`default_nettype none

module mul_top #(
  parameter int IN_DEPTH    = 4,
  parameter int OUT_CREDITS = 4
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              req_valid_i,
  input  mul_pkg::mul_req_t req_i,
  output logic              req_crd_o,
  output logic              res_valid_o,
  output mul_pkg::mul_res_t res_o,
  input  logic              res_crd_i
);

  // Every level's rows live side by side, level 0 at the bottom.
  localparam int ROW_TOTAL = mul_pkg::csa_offset(mul_pkg::CSA_LEVELS + 1);

  mul_pkg::mul_ctrl_t                issue_ctrl;
  mul_pkg::mul_ctrl_t                pp_ctrl;
  logic [mul_pkg::EXT_W-1:0]         rs1_ext;
  logic [mul_pkg::EXT_W-1:0]         rs2_ext;
  mul_pkg::mul_pp_t [ROW_TOTAL-1:0]  tree_rows;
  logic                              res_sent;

  mul_issue #(
    .IN_DEPTH    (IN_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) i_mul_issue (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .req_crd_o   (req_crd_o),
    .res_crd_i   (res_crd_i),
    .res_sent_i  (res_sent),
    .ctrl_o      (issue_ctrl),
    .rs1_ext_o   (rs1_ext),
    .rs2_ext_o   (rs2_ext)
  );

  booth_r4_encoder i_booth_r4_encoder (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .ctrl_i    (issue_ctrl),
    .rs1_ext_i (rs1_ext),
    .rs2_ext_i (rs2_ext),
    .ctrl_o    (pp_ctrl),
    .pp_o      (tree_rows[mul_pkg::PP_COUNT-1:0])
  );

  // 17 -> 12 -> 8 -> 6 -> 4 -> 3 -> 2.
  for (genvar g = 0; g < mul_pkg::CSA_LEVELS; g++) begin : g_csa
    localparam int IN_OFF  = mul_pkg::csa_offset(g);
    localparam int N_IN    = mul_pkg::csa_rows(g);
    localparam int OUT_OFF = mul_pkg::csa_offset(g + 1);
    localparam int N_OUT   = mul_pkg::csa_rows(g + 1);

    csa_level #(
      .N_IN (N_IN)
    ) i_csa_level (
      .rows_i (tree_rows[IN_OFF+N_IN-1:IN_OFF]),
      .rows_o (tree_rows[OUT_OFF+N_OUT-1:OUT_OFF])
    );
  end

  mul_result_stage i_mul_result_stage (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .ctrl_i      (pp_ctrl),
    .rows_i      (tree_rows[ROW_TOTAL-1:ROW_TOTAL-2]),
    .res_valid_o (res_valid_o),
    .res_o       (res_o),
    .res_sent_o  (res_sent)
  );

endmodule

`default_nettype wire

/* hw/mul_result_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module mul_result_stage (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  mul_pkg::mul_ctrl_t          ctrl_i,
  input  mul_pkg::mul_pp_t [1:0]      rows_i,
  output logic                        res_valid_o,
  output mul_pkg::mul_res_t           res_o,
  output logic                        res_sent_o
);

  mul_pkg::mul_ctrl_t     ctrl_q;
  mul_pkg::mul_pp_t [1:0] rows_q;
  mul_pkg::mul_pp_t       sum;
  mul_pkg::mul_data_t     word;
  logic                   valid_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ctrl_q <= '0;
    end else begin
      ctrl_q <= ctrl_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ctrl_i.valid) begin
      rows_q <= rows_i;
    end
  end

  // Final carry-propagate add.
  assign sum  = rows_q[0] + rows_q[1];
  assign word = ctrl_q.sel_high ? sum[63:32] : sum[31:0];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= ctrl_q.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ctrl_q.valid) begin
      res_o.tag  <= ctrl_q.tag;
      res_o.data <= word;
    end
  end

  assign res_valid_o = valid_q;
  // Tells the issue stage a pipeline slot is free.
  assign res_sent_o  = valid_q;

endmodule

`default_nettype wire

/* hw/csa_level.sv */
`timescale 1ns/1ns
`default_nettype none

module csa_level #(
  parameter int N_IN = 3
) (
  input  mul_pkg::mul_pp_t [N_IN-1:0]                        rows_i,
  output mul_pkg::mul_pp_t [mul_pkg::csa_out_rows(N_IN)-1:0] rows_o
);

  localparam int N_GRP = N_IN / 3;
  localparam int N_REM = N_IN % 3;

  // Full-adder row per group of three.
  for (genvar g = 0; g < N_GRP; g++) begin : g_fa
    mul_pkg::mul_pp_t a;
    mul_pkg::mul_pp_t b;
    mul_pkg::mul_pp_t c;

    assign a = rows_i[3*g];
    assign b = rows_i[3*g+1];
    assign c = rows_i[3*g+2];

    assign rows_o[2*g]   = a ^ b ^ c;
    // Carry out of bit 63 falls off, sums are modulo 2^64.
    assign rows_o[2*g+1] = ((a & b) | (a & c) | (b & c)) << 1;
  end

  // Leftovers.
  for (genvar r = 0; r < N_REM; r++) begin : g_pass
    assign rows_o[2*N_GRP+r] = rows_i[3*N_GRP+r];
  end

endmodule

`default_nettype wire

/* hw/booth_r4_encoder.sv */
`timescale 1ns/1ns
`default_nettype none

module booth_r4_encoder (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  mul_pkg::mul_ctrl_t                          ctrl_i,
  input  logic [mul_pkg::EXT_W-1:0]                   rs1_ext_i,
  input  logic [mul_pkg::EXT_W-1:0]                   rs2_ext_i,
  output mul_pkg::mul_ctrl_t                          ctrl_o,
  output mul_pkg::mul_pp_t [mul_pkg::PP_COUNT-1:0]    pp_o
);

  localparam int EXT_W = mul_pkg::EXT_W;
  localparam int PP_W  = mul_pkg::PP_W;

  logic [EXT_W:0]                           scan;
  logic [EXT_W-1:0]                         x_neg;
  logic [EXT_W-1:0]                         x_dbl;
  logic [EXT_W-1:0]                         x_neg_dbl;
  mul_pkg::mul_pp_t [mul_pkg::PP_COUNT-1:0] pp_d;

  // Implicit zero below the multiplier LSB.
  assign scan      = {rs2_ext_i, 1'b0};
  assign x_neg     = ~rs1_ext_i + 1'b1;
  assign x_dbl     = {rs1_ext_i[EXT_W-2:0], 1'b0};
  assign x_neg_dbl = {x_neg[EXT_W-2:0], 1'b0};

  for (genvar i = 0; i < mul_pkg::PP_COUNT; i++) begin : g_digit
    logic [2:0]       digit;
    logic [EXT_W-1:0] sel;

    assign digit = scan[2*i+2 -: 3];

    always_comb begin
      case (digit)
        3'b001, 3'b010: sel = rs1_ext_i;
        3'b011:         sel = x_dbl;
        3'b100:         sel = x_neg_dbl;
        3'b101, 3'b110: sel = x_neg;
        default:        sel = '0;
      endcase
    end

    // Sign-extend to full width, then weight by 4^i.
    assign pp_d[i] = {{(PP_W - EXT_W){sel[EXT_W-1]}}, sel} << (2 * i);
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ctrl_o <= '0;
    end else begin
      ctrl_o <= ctrl_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ctrl_i.valid) begin
      pp_o <= pp_d;
    end
  end

endmodule

`default_nettype wire

/* hw/mul_issue.sv */
`timescale 1ns/1ns
`default_nettype none

module mul_issue #(
  parameter int IN_DEPTH    = 4,
  parameter int OUT_CREDITS = 4
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         req_valid_i,
  input  mul_pkg::mul_req_t            req_i,
  output logic                         req_crd_o,
  input  logic                         res_crd_i,
  input  logic                         res_sent_i,
  output mul_pkg::mul_ctrl_t           ctrl_o,
  output logic [mul_pkg::EXT_W-1:0]    rs1_ext_o,
  output logic [mul_pkg::EXT_W-1:0]    rs2_ext_o
);

  localparam int PTR_W      = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
  localparam int CNT_W      = $clog2(IN_DEPTH + 1);
  localparam int CRD_W      = $clog2(OUT_CREDITS + 1);

  mul_pkg::mul_req_t fifo_mem [IN_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [CNT_W-1:0]  count_q;
  logic [CRD_W-1:0]  crd_q;
  mul_pkg::mul_req_t head;
  logic              pop;
  logic              rs1_signed;
  logic              rs2_signed;
  logic              sel_high;

  assign head = fifo_mem[rd_ptr_q];

  assign pop = (count_q != '0) && (crd_q != '0);

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      fifo_mem[wr_ptr_q] <= req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      crd_q      <= CRD_W'(OUT_CREDITS);
    end else begin
      if (req_valid_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(IN_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(IN_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q    <= count_q + CNT_W'(req_valid_i) - CNT_W'(pop);
      // Credit is taken at issue and given back by the receiver.
      crd_q      <= crd_q + CRD_W'(res_crd_i) - CRD_W'(pop);
    end
  end

  always_comb begin
    rs1_signed = 1'b0;
    rs2_signed = 1'b0;
    sel_high   = 1'b1;
    case (head.op)
      mul_pkg::OP_MUL: begin
        sel_high = 1'b0;
      end
      mul_pkg::OP_MULH: begin
        rs1_signed = 1'b1;
        rs2_signed = 1'b1;
      end
      mul_pkg::OP_MULHSU: begin
        rs1_signed = 1'b1;
      end
      mul_pkg::OP_MULHU: begin
        sel_high = 1'b1;
      end
    endcase
  end

  assign rs1_ext_o = {{2{rs1_signed & head.rs1[31]}}, head.rs1};
  assign rs2_ext_o = {{2{rs2_signed & head.rs2[31]}}, head.rs2};

  assign ctrl_o.valid    = pop;
  assign ctrl_o.tag      = head.tag;
  assign ctrl_o.sel_high = sel_high;

  // One credit back to the sender per FIFO pop.
  assign req_crd_o = pop;

endmodule

`default_nettype wire

/* hw/mul_pkg.sv */
`default_nettype none

package mul_pkg;

  localparam int DATA_W     = 32;
  localparam int PP_W       = 64;
  localparam int TAG_W      = 4;
  localparam int EXT_W      = 34;
  localparam int PP_COUNT   = 17;
  localparam int CSA_LEVELS = 6;

  typedef logic [DATA_W-1:0] mul_data_t;
  typedef logic [PP_W-1:0]   mul_pp_t;
  typedef logic [TAG_W-1:0]  mul_tag_t;
  typedef logic [1:0]        mul_op_t;

  // Same order as funct3[1:0] of the M extension.
  localparam mul_op_t OP_MUL    = 2'd0;
  localparam mul_op_t OP_MULH   = 2'd1;
  localparam mul_op_t OP_MULHSU = 2'd2;
  localparam mul_op_t OP_MULHU  = 2'd3;

  typedef struct packed {
    mul_op_t   op;
    mul_tag_t  tag;
    mul_data_t rs1;
    mul_data_t rs2;
  } mul_req_t;

  typedef struct packed {
    mul_tag_t  tag;
    mul_data_t data;
  } mul_res_t;

  typedef struct packed {
    logic     valid;
    mul_tag_t tag;
    logic     sel_high;
  } mul_ctrl_t;

  // Rows left after one 3:2 level.
  function automatic int csa_out_rows(int n_in);
    return 2 * (n_in / 3) + n_in % 3;
  endfunction

  // Rows entering a given level of the tree.
  function automatic int csa_rows(int lvl);
    int n;
    n = PP_COUNT;
    for (int l = 0; l < lvl; l++) begin
      n = csa_out_rows(n);
    end
    return n;
  endfunction

  // Position of a level's rows in the flattened row vector.
  function automatic int csa_offset(int lvl);
    int off;
    off = 0;
    for (int l = 0; l < lvl; l++) begin
      off += csa_rows(l);
    end
    return off;
  endfunction

endpackage

`default_nettype wire
